// File: logic/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  wire alu_uart_pkg::alu_request_t      i_request,
   output logic [alu_uart_pkg::DATA_BITS-1:0]   o_result
);

   import alu_uart_pkg::*;

   logic signed [DATA_BITS-1:0] a_signed;

   assign a_signed = i_request.a;                  // Sign source for SRA

   always_comb begin
      case (i_request.op)
         OP_ADD: o_result = i_request.a + i_request.b;      // Wraps at 8 bits
         OP_SUB: o_result = i_request.a - i_request.b;
         OP_AND: o_result = i_request.a & i_request.b;
         OP_OR:  o_result = i_request.a | i_request.b;
         OP_XOR: o_result = i_request.a ^ i_request.b;
         OP_NOR: o_result = ~(i_request.a | i_request.b);
         OP_SRA: o_result = a_signed >>> i_request.b;       // Fills with bit 7
         OP_SRL: o_result = i_request.a >> i_request.b;
         default: o_result = '0;                            // Unknown opcode
      endcase
   end

endmodule

`default_nettype wire

// File: logic/alu_uart_pkg.sv
`default_nettype none

package alu_uart_pkg;

   localparam int DATA_BITS  = 8;                  // Byte and operand width
   localparam int OP_BITS    = 6;                  // Opcode width
   localparam int OVERSAMPLE = 16;                 // Ticks per bit
   localparam int TICK_DIV   = 2;                  // Clocks per tick, kept small for fast sim
   localparam int HALF_BIT   = OVERSAMPLE / 2;     // Ticks from start edge to mid start bit
   localparam int FRAME_BITS = DATA_BITS + 2;      // Start, data, stop

   localparam int TICK_CNT_BITS = $clog2(OVERSAMPLE);
   localparam int BIT_CNT_BITS  = $clog2(FRAME_BITS);
   localparam int DIV_CNT_BITS  = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

   // Opcode values, taken from the low six bits of the third byte
   localparam logic [OP_BITS-1:0] OP_ADD = 6'b100000;
   localparam logic [OP_BITS-1:0] OP_SUB = 6'b100010;
   localparam logic [OP_BITS-1:0] OP_AND = 6'b100100;
   localparam logic [OP_BITS-1:0] OP_OR  = 6'b100101;
   localparam logic [OP_BITS-1:0] OP_XOR = 6'b100110;
   localparam logic [OP_BITS-1:0] OP_NOR = 6'b100111;
   localparam logic [OP_BITS-1:0] OP_SRA = 6'b000011;
   localparam logic [OP_BITS-1:0] OP_SRL = 6'b000010;

   typedef struct packed {
      logic [DATA_BITS-1:0] a;                     // First operand byte
      logic [DATA_BITS-1:0] b;                     // Second operand, also the shift count
      logic [OP_BITS-1:0]   op;
   } alu_request_t;

endpackage

`default_nettype wire

// File: logic/baud_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen (
   input  wire logic i_clock,
   input  wire logic i_reset,
   output logic      o_tick
);

   import alu_uart_pkg::*;

   logic [DIV_CNT_BITS-1:0] div_cnt;

   // Free running, so the tick phase has no relation to incoming frames
   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         div_cnt <= '0;
         o_tick  <= 1'b0;
      end else if (div_cnt == DIV_CNT_BITS'(TICK_DIV - 1)) begin
         div_cnt <= '0;
         o_tick  <= 1'b1;                          // One clock wide
      end else begin
         div_cnt <= div_cnt + 1'b1;
         o_tick  <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: logic/operand_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module operand_sequencer (
   input  wire logic                            i_clock,
   input  wire logic                            i_reset,
   input  wire logic [alu_uart_pkg::DATA_BITS-1:0] i_rx_data,
   input  wire logic                            i_rx_valid,
   input  wire logic [alu_uart_pkg::DATA_BITS-1:0] i_result,
   input  wire logic                            i_tx_busy,
   input  wire logic                            i_tx_done,
   output alu_uart_pkg::alu_request_t           o_request,
   output logic [alu_uart_pkg::DATA_BITS-1:0]   o_tx_data,
   output logic                                 o_tx_start
);

   import alu_uart_pkg::*;

   typedef enum logic [4:0] {
      ST_TAKE_A    = 5'b00001,
      ST_TAKE_B    = 5'b00010,
      ST_TAKE_OP   = 5'b00100,
      ST_SEND      = 5'b01000,
      ST_WAIT_DONE = 5'b10000
   } seq_state_t;

   seq_state_t state;
   seq_state_t state_next;

   always_comb begin
      state_next = state;
      case (state)
         ST_TAKE_A: begin
            if (i_rx_valid) state_next = ST_TAKE_B;
         end
         ST_TAKE_B: begin
            if (i_rx_valid) state_next = ST_TAKE_OP;
         end
         ST_TAKE_OP: begin
            if (i_rx_valid) state_next = ST_SEND;
         end
         ST_SEND: begin
            if (!i_tx_busy) state_next = ST_WAIT_DONE;
         end
         ST_WAIT_DONE: begin
            if (i_tx_done) state_next = ST_TAKE_A;   // Bytes seen here are dropped
         end
         default: state_next = ST_TAKE_A;
      endcase
   end

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         state      <= ST_TAKE_A;
         o_tx_start <= 1'b0;
      end else begin
         state      <= state_next;
         o_tx_start <= (state == ST_SEND) && !i_tx_busy;   // Lines up with o_tx_data
      end
   end

   // Operand capture, one field per received byte
   always_ff @(posedge i_clock) begin
      if (i_rx_valid) begin
         case (state)
            ST_TAKE_A:  o_request.a  <= i_rx_data;
            ST_TAKE_B:  o_request.b  <= i_rx_data;
            ST_TAKE_OP: o_request.op <= i_rx_data[OP_BITS-1:0];   // Upper bits ignored
            default: ;
         endcase
      end
   end

   // ALU has settled on the new opcode by the first cycle in ST_SEND
   always_ff @(posedge i_clock) begin
      if (state == ST_SEND) o_tx_data <= i_result;
   end

endmodule

`default_nettype wire

// File: logic/uart_alu_top.sv
`timescale 1ns/1ps
`default_nettype none

module uart_alu_top (
   input  wire logic clock,
   input  wire logic reset,
   input  wire logic i_rx,
   output logic      o_tx
);

   import alu_uart_pkg::*;

   logic                 tick;
   logic [DATA_BITS-1:0] rx_data;
   logic                 rx_valid;
   alu_request_t         request;
   logic [DATA_BITS-1:0] result;
   logic [DATA_BITS-1:0] tx_data;
   logic                 tx_start;
   logic                 tx_busy;
   logic                 tx_done;

   baud_tick_gen u_tick (
      .i_clock (clock),
      .i_reset (reset),
      .o_tick  (tick)
   );

   uart_rx u_rx (
      .i_clock (clock),
      .i_reset (reset),
      .i_tick  (tick),
      .i_rx    (i_rx),
      .o_data  (rx_data),
      .o_valid (rx_valid)
   );

   operand_sequencer u_seq (
      .i_clock    (clock),
      .i_reset    (reset),
      .i_rx_data  (rx_data),
      .i_rx_valid (rx_valid),
      .i_result   (result),
      .i_tx_busy  (tx_busy),
      .i_tx_done  (tx_done),
      .o_request  (request),
      .o_tx_data  (tx_data),
      .o_tx_start (tx_start)
   );

   alu u_alu (
      .i_request (request),
      .o_result  (result)
   );

   uart_tx u_tx (
      .i_clock (clock),
      .i_reset (reset),
      .i_tick  (tick),
      .i_start (tx_start),
      .i_data  (tx_data),
      .o_tx    (o_tx),
      .o_busy  (tx_busy),
      .o_done  (tx_done)
   );

endmodule

`default_nettype wire

// File: logic/uart_rx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
   input  wire logic                            i_clock,
   input  wire logic                            i_reset,
   input  wire logic                            i_tick,
   input  wire logic                            i_rx,
   output logic [alu_uart_pkg::DATA_BITS-1:0]   o_data,
   output logic                                 o_valid
);

   import alu_uart_pkg::*;

   typedef enum logic [1:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_STOP
   } rx_state_t;

   rx_state_t                state;
   logic                     rx_meta;
   logic                     rx_sync;
   logic                     rx_prev;
   logic [TICK_CNT_BITS-1:0] tick_cnt;
   logic [BIT_CNT_BITS-1:0]  bit_cnt;
   logic [DATA_BITS-1:0]     shift;
   logic                     bit_end;

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         rx_meta <= 1'b1;                          // Line idles high
         rx_sync <= 1'b1;
         rx_prev <= 1'b1;
      end else begin
         rx_meta <= i_rx;
         rx_sync <= rx_meta;
         rx_prev <= rx_sync;                       // For falling edge detect
      end
   end

   assign bit_end = i_tick && (tick_cnt == TICK_CNT_BITS'(OVERSAMPLE - 1));

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         state    <= RX_IDLE;
         tick_cnt <= '0;
         bit_cnt  <= '0;
         o_valid  <= 1'b0;
      end else begin
         o_valid <= 1'b0;
         case (state)
            RX_IDLE: begin
               tick_cnt <= '0;
               bit_cnt  <= '0;
               if (rx_prev && !rx_sync) state <= RX_START;
            end
            RX_START: begin
               if (i_tick && tick_cnt == TICK_CNT_BITS'(HALF_BIT - 1)) begin
                  tick_cnt <= '0;
                  state    <= rx_sync ? RX_IDLE : RX_DATA;   // Glitch, not a start bit
               end else if (i_tick) begin
                  tick_cnt <= tick_cnt + 1'b1;
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  tick_cnt <= '0;
                  bit_cnt  <= bit_cnt + 1'b1;
                  if (bit_cnt == BIT_CNT_BITS'(DATA_BITS - 1)) state <= RX_STOP;
               end else if (i_tick) begin
                  tick_cnt <= tick_cnt + 1'b1;
               end
            end
            RX_STOP: begin
               if (bit_end) begin
                  o_valid <= rx_sync;              // Low stop bit drops the byte
                  state   <= RX_IDLE;
               end else if (i_tick) begin
                  tick_cnt <= tick_cnt + 1'b1;
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   always_ff @(posedge i_clock) begin
      if (state == RX_DATA && bit_end) shift <= {rx_sync, shift[DATA_BITS-1:1]};  // LSB first
      if (state == RX_STOP && bit_end && rx_sync) o_data <= shift;
   end

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
   input  wire logic                            i_clock,
   input  wire logic                            i_reset,
   input  wire logic                            i_tick,
   input  wire logic                            i_start,
   input  wire logic [alu_uart_pkg::DATA_BITS-1:0] i_data,
   output logic                                 o_tx,
   output logic                                 o_busy,
   output logic                                 o_done
);

   import alu_uart_pkg::*;

   logic [FRAME_BITS-1:0]    shift;
   logic [TICK_CNT_BITS-1:0] tick_cnt;
   logic [BIT_CNT_BITS-1:0]  bit_cnt;
   logic                     pending;              // Accepted, waiting for tick boundary
   logic                     sending;
   logic                     accept;
   logic                     bit_end;

   assign accept  = i_start && !o_busy;
   assign bit_end = sending && i_tick && (tick_cnt == TICK_CNT_BITS'(OVERSAMPLE - 1));

   always_ff @(posedge i_clock) begin
      if (i_reset) begin
         pending  <= 1'b0;
         sending  <= 1'b0;
         o_busy   <= 1'b0;
         o_done   <= 1'b0;
         o_tx     <= 1'b1;
         tick_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         o_done <= 1'b0;
         if (accept) begin
            pending <= 1'b1;
            o_busy  <= 1'b1;
         end else if (pending && i_tick) begin
            pending  <= 1'b0;
            sending  <= 1'b1;
            o_tx     <= shift[0];                  // Start bit
            tick_cnt <= '0;
            bit_cnt  <= '0;
         end else if (bit_end) begin
            tick_cnt <= '0;
            if (bit_cnt == BIT_CNT_BITS'(FRAME_BITS - 1)) begin
               sending <= 1'b0;                    // Stop bit finished, line stays high
               o_busy  <= 1'b0;
               o_done  <= 1'b1;
            end else begin
               bit_cnt <= bit_cnt + 1'b1;
               o_tx    <= shift[1];
            end
         end else if (sending && i_tick) begin
            tick_cnt <= tick_cnt + 1'b1;
         end
      end
   end

   always_ff @(posedge i_clock) begin
      if (accept) begin
         shift <= {1'b1, i_data, 1'b0};            // Stop, data, start
      end else if (bit_end) begin
         shift <= {1'b1, shift[FRAME_BITS-1:1]};
      end
   end

endmodule

`default_nettype wire

// File: project.f
logic/alu_uart_pkg.sv
logic/baud_tick_gen.sv
logic/uart_rx.sv
logic/operand_sequencer.sv
logic/alu.sv
logic/uart_tx.sv
logic/uart_alu_top.sv
sim/uart_alu_props.sv
sim/uart_alu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the UART ALU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f --top-module uart_alu_tb -o uart_alu_sim

output=$(./obj_dir/uart_alu_sim)
echo "$output"

if echo "$output" | grep -qx "Test passed"; then
   exit 0
else
   exit 1
fi

// File: sim/uart_alu_props.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx_props (
   input wire logic                                  i_clock,
   input wire logic                                  i_reset,
   input wire logic                                  i_start,
   input wire logic                                  i_tx,
   input wire logic                                  i_busy,
   input wire logic                                  i_done,
   input wire logic                                  i_sending,
   input wire logic [alu_uart_pkg::BIT_CNT_BITS-1:0] i_bit_cnt
);

   import alu_uart_pkg::*;

   int assert_failures;                            // Count of failed properties

   assert property (@(posedge i_clock) disable iff (i_reset) !i_busy |-> i_tx)
      else begin
         $error("o_tx low while the transmitter is idle");
         assert_failures++;
      end

   assert property (@(posedge i_clock) disable iff (i_reset) i_start |-> !i_busy)
      else begin
         $error("Start strobe while the transmitter is busy");
         assert_failures++;
      end

   // No new frame may be started in the cycle of the done pulse
   assert property (@(posedge i_clock) disable iff (i_reset) i_done |=> !i_busy)
      else begin
         $error("Busy high again right after the done pulse");
         assert_failures++;
      end

   // Start bit low for 32 clocks, then the first data bit
   assert property (@(posedge i_clock) disable iff (i_reset)
      $rose(i_sending) |-> !i_tx ##31 !i_tx ##1 (i_bit_cnt == BIT_CNT_BITS'(1)))
      else begin
         $error("Start bit does not last one bit time");
         assert_failures++;
      end

   // Stop bit high and entered exactly one bit time before done
   assert property (@(posedge i_clock) disable iff (i_reset)
      i_done |-> i_tx && $past(i_tx, 32)
                 && ($past(i_bit_cnt, 33) == BIT_CNT_BITS'(FRAME_BITS - 2)))
      else begin
         $error("Stop bit is not high for one bit time");
         assert_failures++;
      end

endmodule

bind uart_tx uart_tx_props u_props (
   .i_clock   (i_clock),
   .i_reset   (i_reset),
   .i_start   (i_start),
   .i_tx      (o_tx),
   .i_busy    (o_busy),
   .i_done    (o_done),
   .i_sending (sending),
   .i_bit_cnt (bit_cnt)
);

`default_nettype wire

// File: sim/uart_alu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module uart_alu_tb;

   import alu_uart_pkg::*;

   localparam int          BIT_CLOCKS   = OVERSAMPLE * TICK_DIV;   // 32 clocks per bit
   localparam int          FRAME_CLOCKS = BIT_CLOCKS * FRAME_BITS;
   localparam int          RESET_CYCLES = 8;
   localparam int          NUM_OPS      = 18;                      // Directed, random and recovery
   // Four frames per operation plus idle checks and the bad frame, doubled
   localparam int          MAX_CYCLES   = (NUM_OPS * 4 + 6) * FRAME_CLOCKS * 2;
   localparam logic [31:0] SEED         = 32'h2f59cd4e;

   logic                 clock;
   logic                 reset;
   logic                 rx_line;
   logic                 tx_line;
   int                   errors;
   int                   cycles;
   int                   frames_seen;
   logic [DATA_BITS-1:0] tx_bytes[$];              // Decoded result bytes

   uart_alu_top u_dut (
      .clock (clock),
      .reset (reset),
      .i_rx  (rx_line),
      .o_tx  (tx_line)
   );

   initial clock = 1'b0;
   always #4 clock = ~clock;

   always @(posedge clock) begin
      cycles <= cycles + 1;
      if (cycles >= MAX_CYCLES) begin
         $display("Timeout: run stopped after %0d cycles", cycles);
         $display("Test failed");
         $finish;
      end
   end

   // Result of an operation from the opcode rules
   function automatic logic [DATA_BITS-1:0] model_result(input logic [DATA_BITS-1:0] a,
                                                         input logic [DATA_BITS-1:0] b,
                                                         input logic [OP_BITS-1:0]   op);
      logic [DATA_BITS:0]   sum;
      logic [DATA_BITS-1:0] r;
      int                   count;
      count = int'(b);
      r     = '0;
      case (op)
         OP_ADD: begin
            sum = {1'b0, a} + {1'b0, b};
            r   = sum[DATA_BITS-1:0];              // Carry dropped
         end
         OP_SUB: begin
            sum = {1'b0, a} + {1'b0, ~b} + 9'd1;   // Two's complement
            r   = sum[DATA_BITS-1:0];
         end
         OP_AND: r = a & b;
         OP_OR:  r = a | b;
         OP_XOR: r = a ^ b;
         OP_NOR: r = ~(a | b);
         OP_SRA, OP_SRL: begin
            r = a;
            for (int i = 0; i < DATA_BITS; i++) begin
               if (i < count) r = {(op == OP_SRA) ? r[DATA_BITS-1] : 1'b0, r[DATA_BITS-1:1]};
            end
         end
         default: r = '0;
      endcase
      return r;
   endfunction

   task automatic send_frame(input logic [DATA_BITS-1:0] data, input logic stop_bit);
      logic [FRAME_BITS-1:0] bits;
      bits = {stop_bit, data, 1'b0};
      for (int i = 0; i < FRAME_BITS; i++) begin
         @(posedge clock);
         rx_line <= bits[i];                       // LSB first after the start bit
         repeat (BIT_CLOCKS - 1) @(posedge clock);
      end
      if (!stop_bit) begin
         @(posedge clock);
         rx_line <= 1'b1;                          // Back to idle for one bit
         repeat (BIT_CLOCKS - 1) @(posedge clock);
      end
   endtask

   task automatic run_operation(input string name, input logic [DATA_BITS-1:0] a,
                                input logic [DATA_BITS-1:0] b,
                                input logic [DATA_BITS-1:0] op_byte);
      logic [DATA_BITS-1:0] expected;
      logic [DATA_BITS-1:0] actual;
      expected = model_result(a, b, op_byte[OP_BITS-1:0]);
      send_frame(a, 1'b1);
      send_frame(b, 1'b1);
      send_frame(op_byte, 1'b1);
      while (tx_bytes.size() == 0) @(posedge clock);
      actual = tx_bytes.pop_front();
      assert (actual == expected) else begin
         $display("ERR %s expected %02h actual %02h", name, expected, actual);
         errors++;
      end
   endtask

   // Decodes o_tx at mid-bit on the falling clock edge
   always begin : decode_tx
      logic [DATA_BITS-1:0] data;
      @(negedge clock);
      if (!reset && tx_line === 1'b0) begin
         repeat (BIT_CLOCKS / 2 - 1) @(negedge clock);
         assert (tx_line === 1'b0) else begin
            $display("Start bit on o_tx went high before mid-bit");
            errors++;
         end
         for (int i = 0; i < DATA_BITS; i++) begin
            repeat (BIT_CLOCKS) @(negedge clock);
            data[i] = tx_line;
         end
         repeat (BIT_CLOCKS) @(negedge clock);
         assert (tx_line === 1'b1) else begin
            $display("Stop bit on o_tx sampled low");
            errors++;
         end
         tx_bytes.push_back(data);
         frames_seen++;
      end
   end

   initial begin
      logic [DATA_BITS-1:0] a;
      logic [DATA_BITS-1:0] b;
      logic [DATA_BITS-1:0] op_byte;
      logic [2:0]           idx;
      logic [OP_BITS-1:0]   op_table [8];
      int                   total;
      op_table = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_NOR, OP_SRA, OP_SRL};
      void'($urandom(SEED));
      reset   <= 1'b1;
      rx_line <= 1'b1;
      repeat (RESET_CYCLES) @(posedge clock);
      reset <= 1'b0;

      repeat (2 * FRAME_CLOCKS) @(posedge clock);   // No input yet, line must stay idle
      assert (frames_seen == 0 && tx_line === 1'b1) else begin
         $display("o_tx left idle before any input was sent");
         errors++;
      end

      run_operation("add_wrap", 8'hF0, 8'h20, {2'b00, OP_ADD});
      run_operation("sub_wrap", 8'h10, 8'h20, {2'b01, OP_SUB});
      run_operation("and", 8'hCC, 8'hAA, {2'b00, OP_AND});
      run_operation("or", 8'hC0, 8'h0A, {2'b11, OP_OR});
      run_operation("xor", 8'hFF, 8'h5A, {2'b00, OP_XOR});
      run_operation("nor", 8'h81, 8'h42, {2'b10, OP_NOR});
      run_operation("sra_sign", 8'h90, 8'h03, {2'b00, OP_SRA});
      run_operation("srl", 8'h90, 8'h03, {2'b00, OP_SRL});
      run_operation("unknown_op", 8'h5A, 8'hC3, 8'h3F);

      for (int n = 0; n < 8; n++) begin
         a       = 8'($urandom());
         b       = 8'($urandom());
         idx     = 3'($urandom_range(7));
         op_byte = {2'($urandom()), op_table[idx]};   // Upper bits must be ignored
         run_operation($sformatf("random_%0d", n), a, b, op_byte);
      end

      send_frame(8'hA5, 1'b0);                     // Low stop bit, byte is dropped
      run_operation("after_bad_stop", 8'h37, 8'h4C, {2'b11, OP_SUB});

      repeat (2 * FRAME_CLOCKS) @(posedge clock);
      assert (tx_bytes.size() == 0 && frames_seen == NUM_OPS) else begin
         $display("Saw %0d result frames for %0d operations", frames_seen, NUM_OPS);
         errors++;
      end

      total = errors + u_dut.u_tx.u_props.assert_failures;
      $display("Errors: %0d in checks, %0d in assertions", errors,
               u_dut.u_tx.u_props.assert_failures);
      if (total == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire
